//--- dv/rename_tb.sv
`default_nettype none

module rename_tb;

	localparam int n_rand = 60;	// random fetch cycles
	localparam int n_miss = 6;	// branch miss rounds
	localparam int d_cyc  = (rfx_pkg::num_regs + rfx_pkg::iq_entries + 1) * 3;	// one full dump
	localparam int test_cycles = 5 + n_rand + 11 + 19 + n_miss * 10 + 6 + (8 + n_miss) * d_cyc;
	localparam int max_cycles  = test_cycles + 200;

	logic                           clk;
	logic                           rst;
	logic                           fetch0_v;
	rfx_pkg::instruction_t          fetch0_instr;
	logic                           fetch1_v;
	rfx_pkg::instruction_t          fetch1_instr;
	logic                           retire;
	logic                           branchmiss;
	logic [rfx_pkg::iq_idx_w-1:0]   miss_slot;
	logic                           psel;
	logic                           penable;
	logic                           pwrite;
	logic [rfx_pkg::apb_addr_w-1:0] paddr;
	logic [1:0]                     enq_count;
	logic [31:0]                    prdata;
	logic                           pready;
	logic                           pslverr;

	integer seed;
	int     cycles;
	int     err_enq;	// grant mismatches
	int     err_word;	// status word mismatches
	int     err_bus;	// bus response faults
	string  test_name;

	////////////////////////////////////////////////////////////
	// model of queue ring and source table
	////////////////////////////////////////////////////////////
	logic       m_v   [rfx_pkg::iq_entries];
	logic       m_mem [rfx_pkg::iq_entries];
	logic       m_rfw [rfx_pkg::iq_entries];
	logic [4:0] m_tgt [rfx_pkg::iq_entries];
	logic [3:0] m_tab [rfx_pkg::num_regs];	// {bus, slot}
	int         m_head;
	int         m_tail;
	int         m_count;
	logic       m_rebuild;	// recovery second cycle pending

	rename_top dut_i (
		.clk(clk), .rst(rst),
		.fetch0_v(fetch0_v), .fetch0_instr(fetch0_instr),
		.fetch1_v(fetch1_v), .fetch1_instr(fetch1_instr),
		.retire(retire), .branchmiss(branchmiss), .miss_slot(miss_slot),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.enq_count(enq_count), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #10 clk = ~clk;

	// slot 0 first and a pair needs two free and no loop branch in slot 0
	function automatic logic [1:0] grant_ref(input logic v0, input rfx_pkg::instruction_t i0,
			input logic v1, input int free);
		logic back;
		back = i0.br.opcode == rfx_pkg::op_branch && i0.br.disp[15];	// negative disp
		if (!v0 || free < 1)
			return 2'd0;
		if (v1 && free >= 2 && !back)
			return 2'd2;
		return 2'd1;
	endfunction

	// expected status word for an address
	function automatic logic [31:0] expected_word(input logic [7:0] addr);
		int s;
		s = addr[4:2];
		if (addr < rfx_pkg::iq_base && addr[1:0] == 2'b00)
			return {28'd0, m_tab[addr[6:2]]};
		if (addr >= rfx_pkg::iq_base && addr < rfx_pkg::iq_base + 8'h20 && addr[1:0] == 2'b00)
			return m_v[s] ? {24'd0, m_v[s], m_mem[s], m_rfw[s], m_tgt[s]} : 32'd0;
		if (addr == rfx_pkg::cnt_addr)
			return m_count;
		return 32'd0;	// hole
	endfunction

	function automatic rfx_pkg::instruction_t rand_instr();
		rfx_pkg::instruction_t ins;
		ins = $random(seed);
		case ({$random(seed)} % 4)
		0:       ins.r2.opcode = rfx_pkg::op_alu;
		1:       ins.r2.opcode = rfx_pkg::op_load;
		2:       ins.r2.opcode = rfx_pkg::op_store;
		default: ins.br.opcode = rfx_pkg::op_branch;	// disp sign random
		endcase
		return ins;
	endfunction

	function automatic rfx_pkg::instruction_t alu_instr(input logic [4:0] tgt);
		rfx_pkg::instruction_t ins;
		ins = $random(seed);
		ins.r2.opcode = rfx_pkg::op_alu;
		ins.r2.rt     = tgt;
		return ins;
	endfunction

	// one granted instruction into the model ring
	task automatic push_model(input rfx_pkg::instruction_t ins);
		logic [5:0] op;
		op = ins.r2.opcode;
		m_v[m_tail]   = 1'b1;
		m_mem[m_tail] = op == rfx_pkg::op_load || op == rfx_pkg::op_store;
		m_rfw[m_tail] = op == rfx_pkg::op_alu || op == rfx_pkg::op_load;
		m_tgt[m_tail] = ins.r2.rt;
		if (m_rfw[m_tail])
			m_tab[ins.r2.rt] = {m_mem[m_tail], 3'(m_tail)};	// second of a pair lands last
		m_tail  = (m_tail + 1) % 8;
		m_count = m_count + 1;
	endtask

	////////////////////////////////////////////////////////////
	// compare grant mid cycle then step model to next edge
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		logic [1:0] exp_cnt;
		int         keep;
		int         s;
		if (!rst) begin
			exp_cnt = 2'd0;
			if (m_rebuild) begin
				for (int k = 0; k < m_count; k++) begin
					s = (m_head + k) % 8;	// oldest to youngest
					if (m_v[s] && m_rfw[s])
						m_tab[m_tgt[s]] = {m_mem[s], 3'(s)};
				end
				m_rebuild = 1'b0;
			end else if (branchmiss) begin
				keep = ((int'(miss_slot) - m_head) & 7) + 1;	// head..branch
				for (int k = keep; k < 8; k++)
					m_v[(m_head + k) % 8] = 1'b0;
				m_tail    = (miss_slot + 1) % 8;
				m_count   = keep;
				m_rebuild = 1'b1;
			end else begin
				exp_cnt = grant_ref(fetch0_v, fetch0_instr, fetch1_v, 8 - m_count);
				if (retire && m_count > 0) begin
					m_v[m_head] = 1'b0;
					m_head      = (m_head + 1) % 8;
					m_count     = m_count - 1;
				end
				if (exp_cnt != 2'd0)
					push_model(fetch0_instr);
				if (exp_cnt == 2'd2)
					push_model(fetch1_instr);
			end
			if (enq_count !== exp_cnt) begin
				err_enq++;
				$display("Error %s: enq_count expected %0d, actual %0d", test_name, exp_cnt,
					enq_count);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic drive_fetch(input logic v0, input rfx_pkg::instruction_t i0, input logic v1,
			input rfx_pkg::instruction_t i1, input logic ret);
		@(posedge clk);
		fetch0_v     <= v0;
		fetch0_instr <= i0;
		fetch1_v     <= v1;
		fetch1_instr <= i1;
		retire       <= ret;
		branchmiss   <= 1'b0;
	endtask

	task automatic random_step();
		drive_fetch(({$random(seed)} % 4) != 0, rand_instr(), ({$random(seed)} % 2) != 0,
			rand_instr(), ({$random(seed)} % 2) != 0);
	endtask

	task automatic drain_queue();
		repeat (9) drive_fetch(1'b0, '0, 1'b0, '0, 1'b1);	// one pop per cycle
	endtask

	// miss on a live slot while the recovery cycles keep offering work
	task automatic miss_branch();
		@(posedge clk);
		fetch0_v     <= 1'b1;
		fetch0_instr <= rand_instr();
		fetch1_v     <= 1'b1;
		fetch1_instr <= rand_instr();
		retire       <= 1'b1;
		branchmiss   <= 1'b1;
		miss_slot    <= (m_head + {$random(seed)} % m_count) % 8;
		drive_fetch(1'b1, rand_instr(), 1'b1, rand_instr(), 1'b1);
		drive_fetch(1'b0, '0, 1'b0, '0, 1'b0);
	endtask

	// setup then access and sample at end of access
	task automatic apb_access(input logic [7:0] addr, input logic wr, output logic [31:0] data,
			output logic err);
		@(posedge clk);
		fetch0_v   <= 1'b0;
		fetch1_v   <= 1'b0;
		retire     <= 1'b0;
		branchmiss <= 1'b0;
		psel       <= 1'b1;
		penable    <= 1'b0;
		pwrite     <= wr;
		paddr      <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		data = prdata;
		err  = pslverr;
		if (pready !== 1'b1) begin
			err_bus++;
			$display("Error %s: pready was low in the access phase at %h", test_name, addr);
		end
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic check_word(input logic [7:0] addr);
		logic [31:0] data;
		logic        err;
		logic [31:0] exp;
		apb_access(addr, 1'b0, data, err);
		exp = expected_word(addr);
		if (err !== 1'b0) begin
			err_bus++;
			$display("Error %s: a read of mapped address %h returned pslverr", test_name, addr);
		end
		if (data !== exp) begin
			err_word++;
			$display("Error %s: addr %h expected %h, actual %h", test_name, addr, exp, data);
		end
	endtask

	task automatic dump_status();
		for (int r = 0; r < rfx_pkg::num_regs; r++)
			check_word(rfx_pkg::src_base + 8'(r * 4));
		for (int s = 0; s < rfx_pkg::iq_entries; s++)
			check_word(rfx_pkg::iq_base + 8'(s * 4));
		check_word(rfx_pkg::cnt_addr);
	endtask

	initial begin
		logic [31:0]           data;
		logic                  err;
		rfx_pkg::instruction_t ins;
		seed         = 75443;
		clk          = 1'b0;
		rst          = 1'b1;
		fetch0_v     = 1'b0;
		fetch0_instr = '0;
		fetch1_v     = 1'b0;
		fetch1_instr = '0;
		retire       = 1'b0;
		branchmiss   = 1'b0;
		miss_slot    = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		cycles       = 0;
		err_enq      = 0;
		err_word     = 0;
		err_bus      = 0;
		for (int s = 0; s < rfx_pkg::iq_entries; s++)
			m_v[s] = 1'b0;
		for (int r = 0; r < rfx_pkg::num_regs; r++)
			m_tab[r] = '0;
		m_head    = 0;
		m_tail    = 0;
		m_count   = 0;
		m_rebuild = 1'b0;

		test_name = "reset";
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		dump_status();

		test_name = "random_enqueue";
		for (int i = 0; i < n_rand; i++) begin
			random_step();
			if (i % 20 == 19)
				dump_status();
		end

		// loop branch in slot 0 blocks slot 1 and then two writers to r7
		test_name = "same_target";
		drain_queue();
		ins = $random(seed);
		ins.br.opcode = rfx_pkg::op_branch;
		ins.br.disp   = -16'sd4;
		drive_fetch(1'b1, ins, 1'b1, alu_instr(5'd3), 1'b0);
		ins = alu_instr(5'd7);
		ins.r2.opcode = rfx_pkg::op_load;
		drive_fetch(1'b1, alu_instr(5'd7), 1'b1, ins, 1'b0);
		dump_status();

		test_name = "backpressure";
		drain_queue();
		repeat (6)
			drive_fetch(1'b1, alu_instr(5'($random(seed))), 1'b1,
				alu_instr(5'($random(seed))), 1'b0);
		dump_status();
		repeat (4)
			drive_fetch(1'b1, alu_instr(5'($random(seed))), 1'b1,
				alu_instr(5'($random(seed))), 1'b0);
		dump_status();	// table unchanged while full

		test_name = "branch_miss";
		for (int n = 0; n < n_miss; n++) begin
			repeat (5) random_step();
			drive_fetch(1'b1, rand_instr(), 1'b0, '0, 1'b0);	// at least one live entry
			miss_branch();
			dump_status();
		end

		test_name = "apb_errors";
		apb_access(rfx_pkg::src_base, 1'b1, data, err);
		if (err !== 1'b1) begin
			err_bus++;
			$display("Error %s: a write completed without pslverr", test_name);
		end
		apb_access(8'hc4, 1'b0, data, err);
		if (err !== 1'b1) begin
			err_bus++;
			$display("Error %s: a read of unmapped address c4 completed without pslverr",
				test_name);
		end
		dump_status();

		$display("errors: enq_count %0d, status words %0d, bus %0d", err_enq, err_word,
			err_bus);
		if (err_enq + err_word + err_bus == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
verilog/rfx_pkg.sv
verilog/enqueue_fsm.sv
verilog/iq_tail_counter.sv
verilog/issue_queue.sv
verilog/regfile_source.sv
verilog/apb_status_regs.sv
verilog/rename_top.sv
dv/rename_tb.sv

//--- verilog/apb_status_regs.sv
`default_nettype none

module apb_status_regs (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            psel,
	input  wire                            penable,
	input  wire                            pwrite,
	input  wire [rfx_pkg::apb_addr_w-1:0]  paddr,
	input  wire [rfx_pkg::num_regs-1:0][rfx_pkg::src_w-1:0] rf_source,
	input  wire [rfx_pkg::iq_entries-1:0]  iq_v,
	input  wire [rfx_pkg::iq_entries-1:0]  iq_mem,
	input  wire [rfx_pkg::iq_entries-1:0]  iq_rfw,
	input  wire [rfx_pkg::iq_entries-1:0][rfx_pkg::reg_w-1:0] iq_tgt,
	input  wire [rfx_pkg::iq_idx_w:0]      free_count,
	output logic [31:0]                    prdata,
	output logic                           pready,
	output logic                           pslverr
);

	logic [rfx_pkg::apb_addr_w-1:0] off_src;	// byte offsets into each window
	logic [rfx_pkg::apb_addr_w-1:0] off_iq;
	logic [rfx_pkg::reg_w-1:0]      reg_idx;
	logic [rfx_pkg::iq_idx_w-1:0]   slot_idx;
	logic                           aligned;
	logic                           hit_src;
	logic                           hit_iq;
	logic                           hit_cnt;
	logic [rfx_pkg::iq_idx_w:0]     occ;
	logic [31:0]                    rd_word;

	// address decode, below-base offsets wrap high and miss
	assign off_src  = paddr - rfx_pkg::src_base;
	assign off_iq   = paddr - rfx_pkg::iq_base;
	assign reg_idx  = off_src[rfx_pkg::reg_w+1:2];
	assign slot_idx = off_iq[rfx_pkg::iq_idx_w+1:2];
	assign aligned  = paddr[1:0] == 2'b00;
	assign hit_src  = aligned && off_src[rfx_pkg::apb_addr_w-1:2] < rfx_pkg::num_regs;
	assign hit_iq   = aligned && off_iq[rfx_pkg::apb_addr_w-1:2] < rfx_pkg::iq_entries;
	assign hit_cnt  = paddr == rfx_pkg::cnt_addr;

	assign occ = 4'(rfx_pkg::iq_entries) - free_count;

	always_comb begin
		rd_word = '0;
		if (hit_src)
			rd_word[rfx_pkg::src_w-1:0] = rf_source[reg_idx];
		else if (hit_iq)	// empty slot reads as zero
			rd_word[rfx_pkg::reg_w+2:0] = {iq_v[slot_idx], iq_mem[slot_idx],
				iq_rfw[slot_idx], iq_tgt[slot_idx]} & {(rfx_pkg::reg_w+3){iq_v[slot_idx]}};
		else if (hit_cnt)
			rd_word[rfx_pkg::iq_idx_w:0] = occ;
	end

	////////////////////////////////////////////////////////////
	// capture in setup, present in access
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end else if (psel && !penable) begin
			prdata  <= pwrite ? '0 : rd_word;
			pslverr <= pwrite || !(hit_src || hit_iq || hit_cnt);	// read only, holes error
		end else if (!psel)
			pslverr <= 1'b0;
	end

	assign pready = 1'b1;	// zero wait

endmodule

`default_nettype wire

//--- verilog/enqueue_fsm.sv
`default_nettype none

module enqueue_fsm (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            fetch0_v,
	input  wire rfx_pkg::instruction_t     fetch0_instr,
	input  wire                            fetch1_v,
	input  wire rfx_pkg::instruction_t     fetch1_instr,
	input  wire [rfx_pkg::iq_idx_w:0]      free_count,
	input  wire                            branchmiss,
	input  wire                            retire,
	input  wire                            empty,
	output logic [1:0]                     enq_count,
	output logic [rfx_pkg::reg_w-1:0]      enq0_tgt,
	output logic                           enq0_mem,
	output logic                           enq0_rfw,
	output logic [rfx_pkg::reg_w-1:0]      enq1_tgt,
	output logic                           enq1_mem,
	output logic                           enq1_rfw,
	output logic                           do_retire,
	output logic                           flush,
	output logic                           rebuild
);

	logic [1:0] state;	// registered state
	logic [1:0] phase;	// what the datapath sees this cycle
	logic       idle;
	logic       back0;	// slot 0 is a loop branch

	// the miss cycle itself is the flush phase, miss_slot is only good then
	always_comb begin
		phase = state;
		if (state == rfx_pkg::st_idle && branchmiss)
			phase = rfx_pkg::st_flush;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= rfx_pkg::st_idle;
		else begin
			case (phase)
			rfx_pkg::st_flush:   state <= rfx_pkg::st_rebuild;
			rfx_pkg::st_rebuild: state <= rfx_pkg::st_idle;
			default:             state <= rfx_pkg::st_idle;
			endcase
		end
	end

	assign idle    = phase == rfx_pkg::st_idle;
	assign flush   = phase == rfx_pkg::st_flush;
	assign rebuild = phase == rfx_pkg::st_rebuild;

	////////////////////////////////////////////////////////////
	// grant, slot 0 always first
	////////////////////////////////////////////////////////////
	assign back0 = rfx_pkg::fn_is_back_branch(fetch0_instr);

	always_comb begin
		enq_count = 2'd0;
		if (idle && fetch0_v && free_count != '0) begin
			enq_count = 2'd1;
			if (fetch1_v && free_count >= 2 && !back0)	// pair only if room and no loop
				enq_count = 2'd2;
		end
	end

	// decode for the queue and the table
	assign enq0_tgt = fetch0_instr.r2.rt;
	assign enq0_mem = rfx_pkg::fn_is_mem(fetch0_instr);
	assign enq0_rfw = rfx_pkg::fn_writes_reg(fetch0_instr);
	assign enq1_tgt = fetch1_instr.r2.rt;
	assign enq1_mem = rfx_pkg::fn_is_mem(fetch1_instr);
	assign enq1_rfw = rfx_pkg::fn_writes_reg(fetch1_instr);

	assign do_retire = idle && retire && !empty;	// retire dropped while recovering

	// a second miss while recovering would lose its slot
	a_miss_in_idle: assert property (@(posedge clk) disable iff (rst)
		branchmiss |-> state == rfx_pkg::st_idle);

endmodule

`default_nettype wire

//--- verilog/iq_tail_counter.sv
`default_nettype none

module iq_tail_counter (
	input  wire                          clk,
	input  wire                          rst,
	input  wire [1:0]                    enq_count,
	input  wire                          do_retire,
	input  wire                          flush,
	input  wire [rfx_pkg::iq_idx_w-1:0]  miss_slot,
	output logic [rfx_pkg::iq_idx_w-1:0] tail0,
	output logic [rfx_pkg::iq_idx_w-1:0] tail1,
	output logic [rfx_pkg::iq_idx_w-1:0] head,
	output logic [rfx_pkg::iq_idx_w:0]   free_count,
	output logic                         empty
);

	logic [rfx_pkg::iq_idx_w-1:0] tail;
	logic [rfx_pkg::iq_idx_w:0]   count;	// occupied slots, 0..8

	// pointers wrap mod 8 on their own
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tail  <= '0;
			head  <= '0;
			count <= '0;
		end else if (flush) begin
			tail  <= miss_slot + 1'b1;	// just behind the branch
			count <= {1'b0, miss_slot - head} + 1'b1;	// head..miss_slot inclusive
		end else begin
			tail  <= tail + {1'b0, enq_count};
			head  <= head + {2'b00, do_retire};
			count <= count + {2'b00, enq_count} - {3'b000, do_retire};
		end
	end

	assign tail0      = tail;
	assign tail1      = tail + 1'b1;	// second slot of a pair
	assign free_count = 4'(rfx_pkg::iq_entries) - count;
	assign empty      = count == '0;

	// grant and flush together must never overfill the ring
	a_count_max: assert property (@(posedge clk) disable iff (rst)
		count <= 4'(rfx_pkg::iq_entries));

endmodule

`default_nettype wire

//--- verilog/issue_queue.sv
`default_nettype none

module issue_queue (
	input  wire                          clk,
	input  wire                          rst,
	input  wire [1:0]                    enq_count,
	input  wire [rfx_pkg::iq_idx_w-1:0]  tail0,
	input  wire [rfx_pkg::iq_idx_w-1:0]  tail1,
	input  wire [rfx_pkg::iq_idx_w-1:0]  head,
	input  wire [rfx_pkg::reg_w-1:0]     enq0_tgt,
	input  wire                          enq0_mem,
	input  wire                          enq0_rfw,
	input  wire [rfx_pkg::reg_w-1:0]     enq1_tgt,
	input  wire                          enq1_mem,
	input  wire                          enq1_rfw,
	input  wire                          do_retire,
	input  wire                          flush,
	input  wire [rfx_pkg::iq_idx_w-1:0]  miss_slot,
	output logic [rfx_pkg::iq_entries-1:0] iq_v,
	output logic [rfx_pkg::iq_entries-1:0] iq_mem,
	output logic [rfx_pkg::iq_entries-1:0] iq_rfw,
	output logic [rfx_pkg::iq_entries-1:0][rfx_pkg::reg_w-1:0] iq_tgt,
	output logic [rfx_pkg::iq_entries-1:0] latest
);

	logic [rfx_pkg::iq_idx_w-1:0]   age [rfx_pkg::iq_entries];	// distance from head
	logic [rfx_pkg::iq_idx_w-1:0]   miss_age;
	logic [rfx_pkg::iq_entries-1:0] younger;	// behind the missed branch

	always_comb begin
		for (int i = 0; i < rfx_pkg::iq_entries; i++)
			age[i] = i[rfx_pkg::iq_idx_w-1:0] - head;
	end

	assign miss_age = miss_slot - head;

	always_comb begin
		for (int i = 0; i < rfx_pkg::iq_entries; i++)
			younger[i] = age[i] > miss_age;
	end

	////////////////////////////////////////////////////////////
	// valid bits
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			iq_v <= '0;
		else if (flush)
			iq_v <= iq_v & ~younger;	// branch itself survives
		else begin
			if (do_retire)
				iq_v[head] <= 1'b0;
			if (enq_count != 2'd0)
				iq_v[tail0] <= 1'b1;
			if (enq_count == 2'd2)
				iq_v[tail1] <= 1'b1;
		end
	end

	// entry payload
	always_ff @(posedge clk) begin
		if (enq_count != 2'd0) begin
			iq_mem[tail0] <= enq0_mem;
			iq_rfw[tail0] <= enq0_rfw;
			iq_tgt[tail0] <= enq0_tgt;
		end
		if (enq_count == 2'd2) begin
			iq_mem[tail1] <= enq1_mem;
			iq_rfw[tail1] <= enq1_rfw;
			iq_tgt[tail1] <= enq1_tgt;
		end
	end

	// youngest live writer of each target
	always_comb begin
		for (int i = 0; i < rfx_pkg::iq_entries; i++) begin
			latest[i] = iq_v[i] && iq_rfw[i];
			for (int j = 0; j < rfx_pkg::iq_entries; j++) begin
				if (iq_v[j] && iq_rfw[j] && iq_tgt[j] == iq_tgt[i] && age[j] > age[i])
					latest[i] = 1'b0;	// shadowed by a younger one
			end
		end
	end

	// tail pointer and grant must agree on free slots
	a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		enq_count != 2'd0 |-> !iq_v[tail0] && (enq_count != 2'd2 || !iq_v[tail1]));

endmodule

`default_nettype wire

//--- verilog/regfile_source.sv
`default_nettype none

module regfile_source (
	input  wire                          clk,
	input  wire                          rst,
	input  wire [1:0]                    enq_count,
	input  wire [rfx_pkg::iq_idx_w-1:0]  tail0,
	input  wire [rfx_pkg::iq_idx_w-1:0]  tail1,
	input  wire [rfx_pkg::reg_w-1:0]     enq0_tgt,
	input  wire                          enq0_mem,
	input  wire                          enq0_rfw,
	input  wire [rfx_pkg::reg_w-1:0]     enq1_tgt,
	input  wire                          enq1_mem,
	input  wire                          enq1_rfw,
	input  wire                          rebuild,
	input  wire [rfx_pkg::iq_entries-1:0] latest,
	input  wire [rfx_pkg::iq_entries-1:0] iq_mem,
	input  wire [rfx_pkg::iq_entries-1:0][rfx_pkg::reg_w-1:0] iq_tgt,
	output logic [rfx_pkg::num_regs-1:0][rfx_pkg::src_w-1:0]  rf_source
);

	logic wr0;	// slot 0 granted and writes a register
	logic wr1;

	assign wr0 = enq_count != 2'd0 && enq0_rfw;
	assign wr1 = enq_count == 2'd2 && enq1_rfw;

	////////////////////////////////////////////////////////////
	// source table holds {bus, slot} per register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			rf_source <= '0;
		else if (rebuild) begin
			// latest flags are unique per target so no two hits collide
			for (int i = 0; i < rfx_pkg::iq_entries; i++) begin
				if (latest[i])
					rf_source[iq_tgt[i]] <= {iq_mem[i], i[rfx_pkg::iq_idx_w-1:0]};
			end
			// registers with no live writer keep their old entry
		end else begin
			if (wr0)
				rf_source[enq0_tgt] <= {enq0_mem, tail0};
			if (wr1)
				rf_source[enq1_tgt] <= {enq1_mem, tail1};	// last nba wins on same target
		end
	end

endmodule

`default_nettype wire

//--- verilog/rename_top.sv
`default_nettype none

module rename_top (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           fetch0_v,
	input  wire rfx_pkg::instruction_t    fetch0_instr,
	input  wire                           fetch1_v,
	input  wire rfx_pkg::instruction_t    fetch1_instr,
	input  wire                           retire,
	input  wire                           branchmiss,
	input  wire [rfx_pkg::iq_idx_w-1:0]   miss_slot,
	input  wire                           psel,
	input  wire                           penable,
	input  wire                           pwrite,
	input  wire [rfx_pkg::apb_addr_w-1:0] paddr,
	output logic [1:0]                    enq_count,
	output logic [31:0]                   prdata,
	output logic                          pready,
	output logic                          pslverr
);

	// decoded fetch slots
	logic [rfx_pkg::reg_w-1:0] enq0_tgt;
	logic [rfx_pkg::reg_w-1:0] enq1_tgt;
	logic                      enq0_mem;
	logic                      enq0_rfw;
	logic                      enq1_mem;
	logic                      enq1_rfw;
	logic                      do_retire;
	logic                      flush;
	logic                      rebuild;

	// ring pointers
	logic [rfx_pkg::iq_idx_w-1:0] tail0;
	logic [rfx_pkg::iq_idx_w-1:0] tail1;
	logic [rfx_pkg::iq_idx_w-1:0] head;
	logic [rfx_pkg::iq_idx_w:0]   free_count;
	logic                         empty;

	// queue state
	logic [rfx_pkg::iq_entries-1:0] iq_v;
	logic [rfx_pkg::iq_entries-1:0] iq_mem;
	logic [rfx_pkg::iq_entries-1:0] iq_rfw;
	logic [rfx_pkg::iq_entries-1:0] latest;
	logic [rfx_pkg::iq_entries-1:0][rfx_pkg::reg_w-1:0]     iq_tgt;
	logic [rfx_pkg::num_regs-1:0][rfx_pkg::src_w-1:0]       rf_source;

	enqueue_fsm u_fsm (
		.clk(clk), .rst(rst),
		.fetch0_v(fetch0_v), .fetch0_instr(fetch0_instr),
		.fetch1_v(fetch1_v), .fetch1_instr(fetch1_instr),
		.free_count(free_count), .branchmiss(branchmiss),
		.retire(retire), .empty(empty), .enq_count(enq_count),
		.enq0_tgt(enq0_tgt), .enq0_mem(enq0_mem), .enq0_rfw(enq0_rfw),
		.enq1_tgt(enq1_tgt), .enq1_mem(enq1_mem), .enq1_rfw(enq1_rfw),
		.do_retire(do_retire), .flush(flush), .rebuild(rebuild)
	);

	iq_tail_counter u_ptr (
		.clk(clk), .rst(rst), .enq_count(enq_count),
		.do_retire(do_retire), .flush(flush), .miss_slot(miss_slot),
		.tail0(tail0), .tail1(tail1), .head(head),
		.free_count(free_count), .empty(empty)
	);

	issue_queue u_iq (
		.clk(clk), .rst(rst), .enq_count(enq_count),
		.tail0(tail0), .tail1(tail1), .head(head),
		.enq0_tgt(enq0_tgt), .enq0_mem(enq0_mem), .enq0_rfw(enq0_rfw),
		.enq1_tgt(enq1_tgt), .enq1_mem(enq1_mem), .enq1_rfw(enq1_rfw),
		.do_retire(do_retire), .flush(flush), .miss_slot(miss_slot),
		.iq_v(iq_v), .iq_mem(iq_mem), .iq_rfw(iq_rfw),
		.iq_tgt(iq_tgt), .latest(latest)
	);

	regfile_source u_rfs (
		.clk(clk), .rst(rst), .enq_count(enq_count),
		.tail0(tail0), .tail1(tail1),
		.enq0_tgt(enq0_tgt), .enq0_mem(enq0_mem), .enq0_rfw(enq0_rfw),
		.enq1_tgt(enq1_tgt), .enq1_mem(enq1_mem), .enq1_rfw(enq1_rfw),
		.rebuild(rebuild), .latest(latest),
		.iq_mem(iq_mem), .iq_tgt(iq_tgt), .rf_source(rf_source)
	);

	apb_status_regs u_apb (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.rf_source(rf_source), .iq_v(iq_v), .iq_mem(iq_mem),
		.iq_rfw(iq_rfw), .iq_tgt(iq_tgt), .free_count(free_count),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

endmodule

`default_nettype wire

//--- verilog/rfx_pkg.sv
`default_nettype none

package rfx_pkg;

	////////////////////////////////////////////////////////////
	// queue and register file sizes
	////////////////////////////////////////////////////////////
	localparam int iq_entries = 8;
	localparam int iq_idx_w   = 3;	// slot index
	localparam int num_regs   = 32;
	localparam int reg_w      = 5;
	localparam int src_w      = 4;	// {mem bus, slot}

	// enqueue fsm state codes
	localparam logic [1:0] st_idle    = 2'd0;
	localparam logic [1:0] st_flush   = 2'd1;
	localparam logic [1:0] st_rebuild = 2'd2;

	// major opcodes
	localparam logic [5:0] op_alu    = 6'h0c;
	localparam logic [5:0] op_load   = 6'h20;
	localparam logic [5:0] op_store  = 6'h28;
	localparam logic [5:0] op_branch = 6'h10;

	////////////////////////////////////////////////////////////
	// status port map
	////////////////////////////////////////////////////////////
	localparam int apb_addr_w = 8;
	localparam logic [apb_addr_w-1:0] src_base = 8'h00;	// one word per register
	localparam logic [apb_addr_w-1:0] iq_base  = 8'h80;	// one word per slot
	localparam logic [apb_addr_w-1:0] cnt_addr = 8'hc0;	// occupancy

	// one instruction word, two readings of the low 26 bits
	typedef union packed {
		struct packed {
			logic [5:0]       opcode;
			logic [reg_w-1:0] rt;	// target
			logic [reg_w-1:0] ra;
			logic [reg_w-1:0] rb;
			logic [10:0]      func;
		} r2;
		struct packed {
			logic [5:0]        opcode;
			logic [reg_w-1:0]  ra;
			logic [reg_w-1:0]  rb;
			logic signed [15:0] disp;	// word displacement
		} br;
	} instruction_t;

	// alu and load results land in rt
	function automatic logic fn_writes_reg(instruction_t ins);
		return ins.r2.opcode == op_alu || ins.r2.opcode == op_load;
	endfunction

	function automatic logic fn_is_mem(instruction_t ins);
		return ins.r2.opcode == op_load || ins.r2.opcode == op_store;
	endfunction

	// loops predicted taken, nothing behind them is fetched in the same pair
	function automatic logic fn_is_back_branch(instruction_t ins);
		return ins.br.opcode == op_branch && ins.br.disp < 16'sd0;
	endfunction

endpackage

`default_nettype wire
